/* apbPkg.sv */
package apbPkg;

	////////////////////////////////////////
	// bus widths
	////////////////////////////////////////

	localparam int ADDR_W = 6;
	localparam int DATA_W = 16;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic pready;
		logic [DATA_W-1:0] prdata;
		logic pslverr;
	} apbResp;

	////////////////////////////////////////
	// register map
	////////////////////////////////////////

	// byte offsets inside one layer block
	localparam int H_SCROLL_OFS = 0;
	localparam int V_SCROLL_OFS = 4;
	localparam int PRI_OFS = 8;

	// one block per layer, layer index in the upper address bits
	localparam int LAYER_STRIDE = 16;

endpackage

/* build.f */
+incdir+.
geomPkg.sv
apbPkg.sv
rasterCounter.sv
scrollRegs.sv
layerScroller.sv
tileFetchSeq.sv
tilemapAddrGen.sv
tilemapAddrGen_tb.sv

/* geomPkg.sv */
package geomPkg;

	////////////////////////////////////////
	// screen and scroll widths
	////////////////////////////////////////

	// raster counters
	localparam int H_W = 9;
	localparam int V_W = 9;

	// per layer scroll offsets and priority
	localparam int HSCROLL_W = 9;
	localparam int VSCROLL_W = 8;
	localparam int PRI_W = 3;

	// 64x32 tiles of 8x8 pixels
	localparam int COL_W = 6;
	localparam int ROW_W = 5;
	localparam int FINE_W = 3;

	// tile RAM bytes and PROM address fields
	localparam int RD_W = 8;
	localparam int IDX_W = 8;
	localparam int ATTR_W = 2;
	localparam int RA_W = 13;
	localparam int GA_W = 14;

	// layer field of the RAM address, one bit at least
	function automatic int layerBits(input int numLayers);
		return (numLayers > 1) ? $clog2(numLayers) : 1;
	endfunction

	////////////////////////////////////////
	// structs
	////////////////////////////////////////

	typedef struct packed {
		logic [H_W-1:0] hCount;
		logic [V_W-1:0] vCount;
	} rasterPos;

	typedef struct packed {
		logic [HSCROLL_W-1:0] hScroll;
		logic [VSCROLL_W-1:0] vScroll;
		logic [PRI_W-1:0] pri;
	} scrollCfg;

	// scrolled coordinates of one layer
	typedef struct packed {
		logic [COL_W-1:0] tileCol;
		logic [ROW_W-1:0] tileRow;
		logic [FINE_W-1:0] fineRow;
		logic nibble;
	} layerAddr;

	// attr, index, fine row, nibble
	typedef struct packed {
		logic [GA_W-1:0] ga;
		logic valid;
	} tileFetch;

endpackage

/* layerScroller.sv */
`timescale 1ns/1ps

module layerScroller (
	input logic CLK_6M,
	input logic rst,
	input geomPkg::rasterPos pos,
	input geomPkg::scrollCfg cfg,
	output geomPkg::layerAddr addr,
	output logic tileEdge
);

	////////////////////////////////////////
	// scrolled position
	////////////////////////////////////////

	// horizontal sum wraps at 512 pixels
	logic [geomPkg::H_W-1:0] hSum;

	// vertical sum wraps at 256 lines
	logic [geomPkg::VSCROLL_W-1:0] vSum;

	assign hSum = pos.hCount + cfg.hScroll;
	assign vSum = pos.vCount[geomPkg::VSCROLL_W-1:0] + cfg.vScroll;

	////////////////////////////////////////
	// tile edge strobe
	////////////////////////////////////////

	// first pixel of a scrolled tile
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			tileEdge <= 1'b0;
		end else begin
			tileEdge <= (hSum[geomPkg::FINE_W-1:0] == '0);
		end
	end

	////////////////////////////////////////
	// tile coordinates
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		// coarse column, 64 tiles across
		addr.tileCol <= hSum[geomPkg::H_W-1:geomPkg::FINE_W];

		// coarse row, 32 tiles down
		addr.tileRow <= vSum[geomPkg::VSCROLL_W-1:geomPkg::FINE_W];

		// pixel row inside the tile
		addr.fineRow <= vSum[geomPkg::FINE_W-1:0];

		// left or right half of the 8 pixel row
		addr.nibble <= hSum[geomPkg::FINE_W-1];
	end

endmodule

/* rasterCounter.sv */
`timescale 1ns/1ps

module rasterCounter (
	input logic CLK_6M,
	input logic rst,
	input logic hSyncN,
	input logic vSyncN,
	output geomPkg::rasterPos pos
);

	// sync levels seen at the previous edge
	logic hSyncLast;
	logic vSyncLast;

	// falling edge of each sync
	logic hFall;
	logic vFall;

	assign hFall = ~hSyncN & hSyncLast;
	assign vFall = ~vSyncN & vSyncLast;

	////////////////////////////////////////
	// pixel counters
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			// idle level of both syncs
			hSyncLast <= 1'b1;
			vSyncLast <= 1'b1;
			pos <= '0;
		end else begin
			hSyncLast <= hSyncN;
			vSyncLast <= vSyncN;

			// start of line
			if (hFall) begin
				pos.hCount <= '0;
				pos.vCount <= pos.vCount + 1'b1;
			end else begin
				pos.hCount <= pos.hCount + 1'b1;
			end

			// start of frame, wins over the line step
			if (vFall) begin
				pos.vCount <= '0;
			end
		end
	end

endmodule

/* scrollRegs.sv */
`timescale 1ns/1ps

module scrollRegs #(
	parameter int NUM_LAYERS = 2
) (
	input logic CLK_6M,
	input logic rst,
	input apbPkg::apbReq apbIn,
	output apbPkg::apbResp apbOut,
	output geomPkg::scrollCfg cfg [NUM_LAYERS]
);

	// offset bits within a layer block, layer index above
	localparam int OFS_W = $clog2(apbPkg::LAYER_STRIDE);
	localparam int SEL_W = apbPkg::ADDR_W - OFS_W;

	logic [SEL_W-1:0] layerSel;
	logic [OFS_W-1:0] regOfs;
	logic access;
	logic layerHit;
	logic ofsHit;
	logic wrEn;
	logic [apbPkg::DATA_W-1:0] rdData;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	assign layerSel = apbIn.paddr[apbPkg::ADDR_W-1:OFS_W];
	assign regOfs = apbIn.paddr[OFS_W-1:0];

	// access phase of a transfer
	assign access = apbIn.psel & apbIn.penable;
	assign layerHit = (int'(layerSel) < NUM_LAYERS);
	assign ofsHit = (regOfs == OFS_W'(apbPkg::H_SCROLL_OFS)) ||
		(regOfs == OFS_W'(apbPkg::V_SCROLL_OFS)) ||
		(regOfs == OFS_W'(apbPkg::PRI_OFS));
	assign wrEn = access & apbIn.pwrite & layerHit & ofsHit;

	// no wait states
	assign apbOut.pready = 1'b1;
	assign apbOut.prdata = rdData;
	assign apbOut.pslverr = access & ~(layerHit & ofsHit);

	// read mux, zero extended fields
	always_comb begin
		rdData = '0;
		for (int k = 0; k < NUM_LAYERS; k++) begin
			if (layerSel == SEL_W'(k)) begin
				case (regOfs)
					OFS_W'(apbPkg::H_SCROLL_OFS):
						rdData[geomPkg::HSCROLL_W-1:0] = cfg[k].hScroll;
					OFS_W'(apbPkg::V_SCROLL_OFS):
						rdData[geomPkg::VSCROLL_W-1:0] = cfg[k].vScroll;
					OFS_W'(apbPkg::PRI_OFS):
						rdData[geomPkg::PRI_W-1:0] = cfg[k].pri;
					default:
						rdData = '0;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// register writes
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			for (int k = 0; k < NUM_LAYERS; k++) begin
				cfg[k] <= '0;
			end
		end else if (wrEn) begin
			for (int k = 0; k < NUM_LAYERS; k++) begin
				if (layerSel == SEL_W'(k)) begin
					// only the field width is kept
					case (regOfs)
						OFS_W'(apbPkg::H_SCROLL_OFS):
							cfg[k].hScroll <= apbIn.pwdata[geomPkg::HSCROLL_W-1:0];
						OFS_W'(apbPkg::V_SCROLL_OFS):
							cfg[k].vScroll <= apbIn.pwdata[geomPkg::VSCROLL_W-1:0];
						OFS_W'(apbPkg::PRI_OFS):
							cfg[k].pri <= apbIn.pwdata[geomPkg::PRI_W-1:0];
						default:
							cfg[k] <= cfg[k];
					endcase
				end
			end
		end
	end

endmodule

/* tileFetchSeq.sv */
`timescale 1ns/1ps

module tileFetchSeq #(
	parameter int NUM_LAYERS = 2
) (
	input logic CLK_6M,
	input logic rst,
	input geomPkg::rasterPos pos,
	input geomPkg::layerAddr addr [NUM_LAYERS],
	output logic [geomPkg::RA_W+geomPkg::layerBits(NUM_LAYERS)-2:0] ra,
	input logic [geomPkg::RD_W-1:0] rd,
	output geomPkg::tileFetch fetch [NUM_LAYERS]
);

	localparam int LAYER_W = geomPkg::layerBits(NUM_LAYERS);

	// repeat bit, byte bit, then layer bits
	localparam int PH_W = $clog2(NUM_LAYERS) + 2;

	// phase in step with the scroller outputs
	logic [PH_W-1:0] phaseD;

	// phase in step with ra
	logic [PH_W-1:0] phaseRa;
	logic [LAYER_W-1:0] selLayer;
	logic [LAYER_W-1:0] raLayer;

	// captured tile bytes and latched fine coordinates
	logic [geomPkg::IDX_W-1:0] tileIdx [NUM_LAYERS];
	logic [geomPkg::ATTR_W-1:0] tileAttr [NUM_LAYERS];
	logic [geomPkg::FINE_W-1:0] fineLat [NUM_LAYERS];
	logic nibLat [NUM_LAYERS];

	// byte 1 just captured
	logic [NUM_LAYERS-1:0] pending;

	assign selLayer = LAYER_W'(phaseD >> 2);
	assign raLayer = LAYER_W'(phaseRa >> 2);

	////////////////////////////////////////
	// slot sequencer
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			phaseD <= '0;
			phaseRa <= '0;
			ra <= '0;
			pending <= '0;
			for (int k = 0; k < NUM_LAYERS; k++) begin
				fetch[k] <= '0;
			end
		end else begin
			phaseD <= pos.hCount[PH_W-1:0];
			phaseRa <= phaseD;

			// layer, row, column, byte
			ra <= {selLayer, addr[selLayer].tileRow, addr[selLayer].tileCol, phaseD[1]};

			for (int k = 0; k < NUM_LAYERS; k++) begin
				// end of the byte 1 slot
				pending[k] <= phaseRa[1] & phaseRa[0] & (raLayer == LAYER_W'(k));

				// one cycle valid pulse
				fetch[k].valid <= pending[k];
				if (pending[k]) begin
					fetch[k].ga <= {tileAttr[k], tileIdx[k], fineLat[k], nibLat[k]};
				end
			end
		end
	end

	////////////////////////////////////////
	// byte capture
	////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		for (int k = 0; k < NUM_LAYERS; k++) begin
			// fine coordinates of the byte 0 address
			if (phaseD[1:0] == 2'b00 && selLayer == LAYER_W'(k)) begin
				fineLat[k] <= addr[k].fineRow;
				nibLat[k] <= addr[k].nibble;
			end

			// rd lags ra by one cycle, so take it in the second slot cycle
			if (phaseRa[0] && raLayer == LAYER_W'(k)) begin
				if (phaseRa[1]) begin
					tileAttr[k] <= rd[geomPkg::ATTR_W-1:0];
				end else begin
					tileIdx[k] <= rd;
				end
			end
		end
	end

endmodule

/* tilemapAddrGen.sv */
`timescale 1ns/1ps

module tilemapAddrGen #(
	parameter int NUM_LAYERS = 2
) (
	input logic CLK_6M,
	input logic rst,
	input logic hSyncN,
	input logic vSyncN,
	input apbPkg::apbReq apbIn,
	output apbPkg::apbResp apbOut,
	output logic [geomPkg::RA_W+geomPkg::layerBits(NUM_LAYERS)-2:0] ra,
	input logic [geomPkg::RD_W-1:0] rd,
	output geomPkg::tileFetch fetch [NUM_LAYERS],
	output logic [NUM_LAYERS-1:0] tileEdge,
	output logic [geomPkg::PRI_W-1:0] layerPri [NUM_LAYERS]
);

	// screen position shared by all layers
	geomPkg::rasterPos pos;

	// cpu side configuration
	geomPkg::scrollCfg cfg [NUM_LAYERS];

	// scrolled coordinates per layer
	geomPkg::layerAddr addr [NUM_LAYERS];

	rasterCounter rasterCounter_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.pos(pos)
	);

	scrollRegs #(
		.NUM_LAYERS(NUM_LAYERS)
	) scrollRegs_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.cfg(cfg)
	);

	////////////////////////////////////////
	// one scroller per layer
	////////////////////////////////////////

	for (genvar k = 0; k < NUM_LAYERS; k++) begin : genLayer
		layerScroller layerScroller_i (
			.CLK_6M(CLK_6M),
			.rst(rst),
			.pos(pos),
			.cfg(cfg[k]),
			.addr(addr[k]),
			.tileEdge(tileEdge[k])
		);

		// priority goes straight on to the mixer
		assign layerPri[k] = cfg[k].pri;
	end

	tileFetchSeq #(
		.NUM_LAYERS(NUM_LAYERS)
	) tileFetchSeq_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.pos(pos),
		.addr(addr),
		.ra(ra),
		.rd(rd),
		.fetch(fetch)
	);

endmodule

/* tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////
// reference model
////////////////////////////////////////

// expected ra for the raster position two cycles back
function automatic logic [12:0] expRaOf(input logic [8:0] h, input logic [8:0] v);
	logic layer;
	logic [8:0] hs;
	logic [7:0] vs;
	layer = h[2];
	hs = h + hScr[layer];
	vs = v[7:0] + vScr[layer];
	return {layer, vs[7:3], hs[8:3], h[1]};
endfunction

function automatic logic [2:0] fineOf(input logic [8:0] v, input logic layer);
	logic [7:0] vs;
	vs = v[7:0] + vScr[layer];
	return vs[2:0];
endfunction

function automatic logic nibOf(input logic [8:0] h, input logic layer);
	logic [8:0] hs;
	hs = h + hScr[layer];
	return hs[2];
endfunction

// first pixel of a scrolled tile
function automatic logic edgeOf(input logic [8:0] h, input logic layer);
	logic [8:0] hs;
	hs = h + hScr[layer];
	return (hs[2:0] == 3'd0);
endfunction

task automatic reportMismatch(input string name, input logic [15:0] exp,
	input logic [15:0] act);
	$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
	errCount++;
endtask

////////////////////////////////////////
// video path checks
////////////////////////////////////////

// full ra, covers column, row and slot order
assert property (@(negedge CLK_6M) disable iff (!chkEn) ra == expRa)
	else reportMismatch("ra", expRa, ra);

// layer and byte bits per slot
assert property (@(negedge CLK_6M) disable iff (!chkEn) {ra[12], ra[0]} == h2[2:1])
	else reportMismatch("ra slot", h2[2:1], {ra[12], ra[0]});

// slot 0 right after a line resync
assert property (@(negedge CLK_6M) disable iff (!chkEn) (h2 == 9'd0) |->
	(ra[6:1] == hScr[0][8:3]))
	else reportMismatch("ra tileCol", hScr[0][8:3], ra[6:1]);

// first row of a frame
assert property (@(negedge CLK_6M) disable iff (!chkEn) (h2 == 9'd0 && v2 == 9'd0) |->
	(ra[11:7] == vScr[0][7:3]))
	else reportMismatch("ra tileRow", vScr[0][7:3], ra[11:7]);

for (genvar k = 0; k < 2; k++) begin : chkLayer
	assert property (@(negedge CLK_6M) disable iff (!chkEn) fetch[k].valid |->
		(fetch[k].ga == {expAttr[k], expIdx[k], expFine[k], expNib[k]}))
		else reportMismatch($sformatf("fetch[%0d].ga", k),
			{expAttr[k], expIdx[k], expFine[k], expNib[k]}, fetch[k].ga);

	assert property (@(negedge CLK_6M) disable iff (!chkEn) tileEdge[k] == edgeOf(h1, k))
		else reportMismatch($sformatf("tileEdge[%0d]", k), edgeOf(h1, k), tileEdge[k]);
end

`endif

/* tilemapAddrGen_tb.sv */
`timescale 1ns/1ps

module tilemapAddrGen_tb;

	localparam int LINE = 64;
	localparam int NUM_CFG = 4;
	// reset, 27 register transfers, then per config 6 lines and 6 register writes
	localparam int TEST_CYCLES = 10 + 27 * 3 + NUM_CFG * (6 * LINE + 6 * 3);
	localparam int LIMIT = TEST_CYCLES * 12 / 10;

	logic CLK_6M;
	logic rst;
	logic hSyncN;
	logic vSyncN;
	apbPkg::apbReq apbIn;
	apbPkg::apbResp apbOut;
	logic [12:0] ra;
	logic [7:0] rd;
	geomPkg::tileFetch fetch [2];
	logic [1:0] tileEdge;
	logic [2:0] layerPri [2];

	// raster model and its two cycle history
	logic [8:0] refH;
	logic [8:0] refV;
	logic hLast;
	logic vLast;
	logic [8:0] h1;
	logic [8:0] h2;
	logic [8:0] v1;
	logic [8:0] v2;
	logic [12:0] expRa;

	// configuration as written
	logic [8:0] hScr [2];
	logic [7:0] vScr [2];
	logic [2:0] priVal [2];

	// expected tile fields per layer
	logic [7:0] expIdx [2];
	logic [1:0] expAttr [2];
	logic [2:0] expFine [2];
	logic expNib [2];

	logic chkEn;
	int errCount;
	int testNum;
	int testErrStart;
	int validSeen;
	int cycles;
	int seed;

	tilemapAddrGen #(
		.NUM_LAYERS(2)
	) tilemapAddrGen_i (
		.CLK_6M(CLK_6M),
		.rst(rst),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.ra(ra),
		.rd(rd),
		.fetch(fetch),
		.tileEdge(tileEdge),
		.layerPri(layerPri)
	);

	`include "tbChecks.svh"

	initial begin
		CLK_6M = 1'b0;
		forever #10 CLK_6M = ~CLK_6M;
	end

	// synchronous tile RAM, one cycle behind ra
	always @(posedge CLK_6M) begin
		if (rst) begin
			rd <= '0;
		end else begin
			rd <= ra[0] ? ra[8:1] : (ra[7:0] ^ 8'h5A);
		end
	end

	////////////////////////////////////////
	// raster model
	////////////////////////////////////////

	assign expRa = expRaOf(h2, v2);

	always @(posedge CLK_6M) begin
		if (rst) begin
			refH <= '0;
			refV <= '0;
			hLast <= 1'b1;
			vLast <= 1'b1;
			h1 <= '0;
			h2 <= '0;
			v1 <= '0;
			v2 <= '0;
		end else begin
			hLast <= hSyncN;
			vLast <= vSyncN;
			refH <= (!hSyncN && hLast) ? 9'd0 : refH + 9'd1;
			if (!vSyncN && vLast) begin
				refV <= '0;
			end else if (!hSyncN && hLast) begin
				refV <= refV + 9'd1;
			end
			h1 <= refH;
			h2 <= h1;
			v1 <= refV;
			v2 <= v1;
		end
	end

	// record the bytes the RAM returns for each slot's first cycle
	always @(posedge CLK_6M) begin
		if (!rst && !h2[0]) begin
			if (!h2[1]) begin
				expIdx[h2[2]] <= expRa[7:0] ^ 8'h5A;
				expFine[h2[2]] <= fineOf(v2, h2[2]);
				expNib[h2[2]] <= nibOf(h2, h2[2]);
			end else begin
				expAttr[h2[2]] <= expRa[2:1];
			end
		end
	end

	always @(posedge CLK_6M) begin
		if (chkEn && (fetch[0].valid || fetch[1].valid)) begin
			validSeen++;
		end
	end

	// run limit
	always @(posedge CLK_6M) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic apbXfer(input logic wr, input logic [5:0] addr, input logic [15:0] wdata,
		output logic [15:0] rdata, output logic err);
		@(negedge CLK_6M);
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = wr;
		apbIn.paddr = addr;
		apbIn.pwdata = wdata;
		@(negedge CLK_6M);
		apbIn.penable = 1'b1;
		@(negedge CLK_6M);
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		checkVal("pready", 16'd1, apbOut.pready);
		apbIn.psel = 1'b0;
		apbIn.penable = 1'b0;
	endtask

	task automatic checkVal(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (exp == act) else reportMismatch(name, exp, act);
	endtask

	// writes one layer and keeps the masked copy
	task automatic writeCfg(input int k, input logic [15:0] h, input logic [15:0] v,
		input logic [15:0] p);
		logic [15:0] rdata;
		logic err;
		apbXfer(1'b1, 6'(k * 16 + 0), h, rdata, err);
		checkVal("pslverr", 16'd0, err);
		apbXfer(1'b1, 6'(k * 16 + 4), v, rdata, err);
		checkVal("pslverr", 16'd0, err);
		apbXfer(1'b1, 6'(k * 16 + 8), p, rdata, err);
		checkVal("pslverr", 16'd0, err);
		hScr[k] = h[8:0];
		vScr[k] = v[7:0];
		priVal[k] = p[2:0];
	endtask

	task automatic readAll();
		logic [15:0] rdata;
		logic err;
		for (int k = 0; k < 2; k++) begin
			apbXfer(1'b0, 6'(k * 16 + 0), 16'd0, rdata, err);
			checkVal($sformatf("hScroll[%0d]", k), {7'd0, hScr[k]}, rdata);
			apbXfer(1'b0, 6'(k * 16 + 4), 16'd0, rdata, err);
			checkVal($sformatf("vScroll[%0d]", k), {8'd0, vScr[k]}, rdata);
			apbXfer(1'b0, 6'(k * 16 + 8), 16'd0, rdata, err);
			checkVal($sformatf("pri[%0d]", k), {13'd0, priVal[k]}, rdata);
			checkVal($sformatf("layerPri[%0d]", k), {13'd0, priVal[k]}, layerPri[k]);
		end
	endtask

	// one 64 pixel line, with a frame start if asked
	task automatic driveLine(input logic frameStart);
		@(negedge CLK_6M);
		hSyncN = 1'b0;
		vSyncN = ~frameStart;
		@(negedge CLK_6M);
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		repeat (LINE - 2) @(negedge CLK_6M);
	endtask

	task automatic endTest(input string name);
		testNum++;
		$display("test %0d %s: %s, %0d errors", testNum, name,
			(errCount == testErrStart) ? "ok" : "FAIL", errCount - testErrStart);
		testErrStart = errCount;
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin
		logic [15:0] rdata;
		logic err;
		int seenBefore;
		seed = 32'h54bd;
		rst = 1'b1;
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		apbIn = '0;
		rd = '0;
		chkEn = 1'b0;
		errCount = 0;
		testNum = 0;
		testErrStart = 0;
		validSeen = 0;
		cycles = 0;
		for (int k = 0; k < 2; k++) begin
			hScr[k] = '0;
			vScr[k] = '0;
			priVal[k] = '0;
		end
		repeat (8) @(negedge CLK_6M);
		rst = 1'b0;

		// state straight out of reset
		checkVal("ra", 16'd0, ra);
		checkVal("fetch valid", 16'd0, {fetch[1].valid, fetch[0].valid});
		checkVal("tileEdge", 16'd0, tileEdge);
		readAll();
		endTest("reset state");

		// register access, fields masked
		writeCfg(0, 16'hFFFF, 16'hFFAB, 16'h000D);
		writeCfg(1, 16'h0123, 16'h0045, 16'h0006);
		readAll();
		// zero data so a stray write to any live field shows up
		apbXfer(1'b1, 6'd12, 16'h0000, rdata, err);
		checkVal("pslverr unmapped write", 16'd1, err);
		apbXfer(1'b1, 6'd32, 16'h0000, rdata, err);
		checkVal("pslverr layer 2 write", 16'd1, err);
		apbXfer(1'b0, 6'd2, 16'd0, rdata, err);
		checkVal("pslverr unmapped read", 16'd1, err);
		readAll();
		endTest("apb registers");

		// video path with random scroll values
		for (int c = 0; c < NUM_CFG; c++) begin
			chkEn = 1'b0;
			seenBefore = validSeen;
			writeCfg(0, 16'($random(seed)), 16'($random(seed)), 16'd1);
			writeCfg(1, 16'($random(seed)), 16'($random(seed)), 16'd2);
			driveLine(1'b0);
			driveLine(1'b0);
			chkEn = 1'b1;
			driveLine(1'b1);
			repeat (3) driveLine(1'b0);
			chkEn = 1'b0;
			if (validSeen == seenBefore) begin
				$display("no fetch valid pulse seen during scroll config %0d", c);
				errCount++;
			end
			endTest($sformatf("video scroll config %0d", c));
		end

		$display("tests %0d, errors %0d", testNum, errCount);
		if (errCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
